//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Bus widths
  typedef logic [15:0] addr_t;
  typedef logic [7:0] data_t;
  typedef logic [12:0] ram_addr_t;

  // Memory map
  localparam addr_t PROGRAM_START = 16'h0200;
  localparam addr_t VRAM_START = 16'hE000;

  // Character grid of the VRAM
  localparam int COLUMNS = 40;
  localparam int ROWS = 25;

  typedef logic [$clog2(COLUMNS * ROWS)-1:0] vram_addr_t;

  // Source or destination register of an instruction
  typedef enum logic [1:0] {
    REG_A = 2'd0,
    REG_X = 2'd1,
    REG_Y = 2'd2
  } reg_sel_t;

  // Load view of the operand word, value in the low byte
  typedef struct packed {
    data_t pad;
    data_t value;
  } load_operand_t;

  // Store address or load value, one word either way
  typedef union packed {
    addr_t addr;
    load_operand_t load;
  } operand_u;

  // Loads
  localparam data_t OPC_LDA_IMM = 8'hA9;
  localparam data_t OPC_LDA_ZP = 8'hA5;
  localparam data_t OPC_LDA_ABS = 8'hAD;
  localparam data_t OPC_LDX_IMM = 8'hA2;
  localparam data_t OPC_LDX_ZP = 8'hA6;
  localparam data_t OPC_LDX_ABS = 8'hAE;
  localparam data_t OPC_LDY_IMM = 8'hA0;
  localparam data_t OPC_LDY_ZP = 8'hA4;
  localparam data_t OPC_LDY_ABS = 8'hAC;

  // Stores
  localparam data_t OPC_STA_ZP = 8'h85;
  localparam data_t OPC_STA_ABS = 8'h8D;
  localparam data_t OPC_STX_ZP = 8'h86;
  localparam data_t OPC_STX_ABS = 8'h8E;
  localparam data_t OPC_STY_ZP = 8'h84;
  localparam data_t OPC_STY_ABS = 8'h8C;

  // Control flow
  localparam data_t OPC_JMP_ABS = 8'h4C;

endpackage

`default_nettype wire

//--- verilog/instr_if.sv
`default_nettype none

// One decoded instruction, fetch side to execute side
interface instr_if import cpu_pkg::*; ();

  logic req;
  logic ack;
  logic is_store;
  reg_sel_t reg_sel;
  operand_u operand;

  modport source(
    output req,
    output is_store,
    output reg_sel,
    output operand,
    input ack
  );

  modport sink(
    input req,
    input is_store,
    input reg_sel,
    input operand,
    output ack
  );

endinterface

`default_nettype wire

//--- verilog/store_if.sv
`default_nettype none

// One store request, execute side to write side
interface store_if import cpu_pkg::*; ();

  logic req;
  logic ack;
  addr_t addr;
  data_t data;

  modport source(
    output req,
    output addr,
    output data,
    input ack
  );

  modport sink(
    input req,
    input addr,
    input data,
    output ack
  );

endinterface

`default_nettype wire

//--- verilog/fetch_unit.sv
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
  parameter int READ_LATENCY = 2
) (
  input wire logic clk,
  input wire logic rst_n,
  output ram_addr_t ram_raddr,
  output logic ram_re,
  input wire data_t ram_rdata,
  instr_if.source instr
);

  localparam int CNT_W = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

  localparam logic [2:0] S_OPCODE = 3'd0;
  localparam logic [2:0] S_OPER_LO = 3'd1;
  localparam logic [2:0] S_OPER_HI = 3'd2;
  localparam logic [2:0] S_DATA = 3'd3;
  localparam logic [2:0] S_HANDOFF = 3'd4;

  logic [2:0] state;
  addr_t pc;
  logic [CNT_W-1:0] lat_cnt;
  logic rd_done;
  addr_t rd_addr;
  logic req_q;

  // Decoded fields of the current opcode
  logic [1:0] op_len;
  logic op_mem;
  logic op_store;
  logic op_jmp;
  reg_sel_t op_reg;
  operand_u operand;

  // Decode of the byte on the read port
  logic [1:0] dec_len;
  logic dec_mem;
  logic dec_store;
  logic dec_jmp;
  reg_sel_t dec_reg;

  assign rd_done = ram_re && (lat_cnt == CNT_W'(READ_LATENCY - 1));

  always_comb begin
    case (state)
      S_OPER_LO: rd_addr = pc + 16'd1;
      S_OPER_HI: rd_addr = pc + 16'd2;
      S_DATA: rd_addr = operand.addr;
      default: rd_addr = pc;
    endcase
  end

  always_comb begin
    dec_len = 2'd1;
    dec_mem = 1'b0;
    dec_store = 1'b0;
    dec_jmp = 1'b0;
    case (ram_rdata)
      OPC_LDA_IMM, OPC_LDX_IMM, OPC_LDY_IMM: dec_len = 2'd2;
      OPC_LDA_ZP, OPC_LDX_ZP, OPC_LDY_ZP: begin
        dec_len = 2'd2;
        dec_mem = 1'b1;
      end
      OPC_LDA_ABS, OPC_LDX_ABS, OPC_LDY_ABS: begin
        dec_len = 2'd3;
        dec_mem = 1'b1;
      end
      OPC_STA_ZP, OPC_STX_ZP, OPC_STY_ZP: begin
        dec_len = 2'd2;
        dec_store = 1'b1;
      end
      OPC_STA_ABS, OPC_STX_ABS, OPC_STY_ABS: begin
        dec_len = 2'd3;
        dec_store = 1'b1;
      end
      OPC_JMP_ABS: begin
        dec_len = 2'd3;
        dec_jmp = 1'b1;
      end
      default: ;
    endcase
    case (ram_rdata)
      OPC_LDX_IMM, OPC_LDX_ZP, OPC_LDX_ABS, OPC_STX_ZP, OPC_STX_ABS: dec_reg = REG_X;
      OPC_LDY_IMM, OPC_LDY_ZP, OPC_LDY_ABS, OPC_STY_ZP, OPC_STY_ABS: dec_reg = REG_Y;
      default: dec_reg = REG_A;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_OPCODE;
      pc <= PROGRAM_START;
      ram_raddr <= '0;
      ram_re <= 1'b0;
      lat_cnt <= '0;
      req_q <= 1'b0;
    end else begin
      // Read pacing, shared by every fetch stage
      if (state != S_HANDOFF) begin
        if (!ram_re) begin
          ram_raddr <= ram_addr_t'(rd_addr);
          ram_re <= 1'b1;
          lat_cnt <= '0;
        end else if (rd_done) begin
          ram_re <= 1'b0;
        end else begin
          lat_cnt <= lat_cnt + 1'b1;
        end
      end
      case (state)
        S_OPCODE: begin
          if (rd_done) begin
            if (dec_len == 2'd1) begin
              // Unknown opcode, skip one byte
              pc <= pc + 16'd1;
            end else begin
              state <= S_OPER_LO;
            end
          end
        end
        S_OPER_LO: begin
          if (rd_done) begin
            if (op_len == 2'd3) begin
              state <= S_OPER_HI;
            end else if (op_mem) begin
              state <= S_DATA;
            end else begin
              state <= S_HANDOFF;
              req_q <= 1'b1;
            end
          end
        end
        S_OPER_HI: begin
          if (rd_done) begin
            if (op_jmp) begin
              pc <= {ram_rdata, operand.addr[7:0]};
              state <= S_OPCODE;
            end else if (op_mem) begin
              state <= S_DATA;
            end else begin
              state <= S_HANDOFF;
              req_q <= 1'b1;
            end
          end
        end
        S_DATA: begin
          if (rd_done) begin
            state <= S_HANDOFF;
            req_q <= 1'b1;
          end
        end
        default: begin
          if (req_q) begin
            if (instr.ack) begin
              req_q <= 1'b0;
            end
          end else if (!instr.ack) begin
            pc <= pc + addr_t'(op_len);
            state <= S_OPCODE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_done) begin
      case (state)
        S_OPCODE: begin
          op_len <= dec_len;
          op_mem <= dec_mem;
          op_store <= dec_store;
          op_jmp <= dec_jmp;
          op_reg <= dec_reg;
        end
        S_OPER_LO: operand.addr <= {8'h00, ram_rdata};
        S_OPER_HI: operand.addr[15:8] <= ram_rdata;
        S_DATA: begin
          operand.load.pad <= 8'h00;
          operand.load.value <= ram_rdata;
        end
        default: ;
      endcase
    end
  end

  assign instr.req = req_q;
  assign instr.is_store = op_store;
  assign instr.reg_sel = op_reg;
  assign instr.operand = operand;

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`default_nettype none

module exec_unit import cpu_pkg::*; (
  input wire logic clk,
  input wire logic rst_n,
  instr_if.sink instr,
  store_if.source st
);

  localparam logic [1:0] E_IDLE = 2'd0;
  localparam logic [1:0] E_STORE = 2'd1;
  localparam logic [1:0] E_ACK = 2'd2;

  logic [1:0] state;
  data_t ra;
  data_t rx;
  data_t ry;
  data_t sel_val;
  logic ack_q;
  logic st_req;
  addr_t st_addr;
  data_t st_data;

  // Register read for stores
  always_comb begin
    case (instr.reg_sel)
      REG_X: sel_val = rx;
      REG_Y: sel_val = ry;
      default: sel_val = ra;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= E_IDLE;
      ra <= '0;
      rx <= '0;
      ry <= '0;
      ack_q <= 1'b0;
      st_req <= 1'b0;
    end else begin
      case (state)
        E_IDLE: begin
          if (instr.req) begin
            if (instr.is_store) begin
              st_req <= 1'b1;
              state <= E_STORE;
            end else begin
              // Load completes right away
              case (instr.reg_sel)
                REG_X: rx <= instr.operand.load.value;
                REG_Y: ry <= instr.operand.load.value;
                default: ra <= instr.operand.load.value;
              endcase
              ack_q <= 1'b1;
              state <= E_ACK;
            end
          end
        end
        E_STORE: begin
          if (st_req) begin
            if (st.ack) begin
              st_req <= 1'b0;
            end
          end else if (!st.ack) begin
            ack_q <= 1'b1;
            state <= E_ACK;
          end
        end
        default: begin
          if (!instr.req) begin
            ack_q <= 1'b0;
            state <= E_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == E_IDLE && instr.req && instr.is_store) begin
      st_addr <= instr.operand.addr;
      st_data <= sel_val;
    end
  end

  assign instr.ack = ack_q;
  assign st.req = st_req;
  assign st.addr = st_addr;
  assign st.data = st_data;

endmodule

`default_nettype wire

//--- verilog/store_unit.sv
`default_nettype none

module store_unit import cpu_pkg::*; (
  input wire logic clk,
  input wire logic rst_n,
  store_if.sink st,
  output ram_addr_t ram_waddr,
  output data_t ram_wdata,
  output logic ram_we,
  output vram_addr_t vram_waddr,
  output data_t vram_wdata,
  output logic vram_we
);

  logic ack_q;
  logic fire;
  logic is_vram;

  // New request not yet answered
  assign fire = st.req && !ack_q;
  assign is_vram = (st.addr >= VRAM_START);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      ram_we <= 1'b0;
      vram_we <= 1'b0;
    end else begin
      // Enables are single-cycle pulses
      ram_we <= fire && !is_vram;
      vram_we <= fire && is_vram;
      if (fire) begin
        ack_q <= 1'b1;
      end else if (ack_q && !st.req) begin
        ack_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      ram_waddr <= ram_addr_t'(st.addr);
      vram_waddr <= vram_addr_t'(st.addr - VRAM_START);
      ram_wdata <= st.data;
      vram_wdata <= st.data;
    end
  end

  assign st.ack = ack_q;

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter int READ_LATENCY = 2
) (
  input wire logic clk,
  input wire logic rst_n,
  output ram_addr_t ram_raddr,
  output logic ram_re,
  input wire data_t ram_rdata,
  output ram_addr_t ram_waddr,
  output data_t ram_wdata,
  output logic ram_we,
  output vram_addr_t vram_waddr,
  output data_t vram_wdata,
  output logic vram_we
);

  instr_if u_instr_if ();
  store_if u_store_if ();

  // Opcode and operand fetch, JMP
  fetch_unit #(
    .READ_LATENCY(READ_LATENCY)
  ) u_fetch_unit (
    .clk(clk),
    .rst_n(rst_n),
    .ram_raddr(ram_raddr),
    .ram_re(ram_re),
    .ram_rdata(ram_rdata),
    .instr(u_instr_if.source)
  );

  // Register file, loads and stores
  exec_unit u_exec_unit (
    .clk(clk),
    .rst_n(rst_n),
    .instr(u_instr_if.sink),
    .st(u_store_if.source)
  );

  // RAM or VRAM write
  store_unit u_store_unit (
    .clk(clk),
    .rst_n(rst_n),
    .st(u_store_if.sink),
    .ram_waddr(ram_waddr),
    .ram_wdata(ram_wdata),
    .ram_we(ram_we),
    .vram_waddr(vram_waddr),
    .vram_wdata(vram_wdata),
    .vram_we(vram_we)
  );

endmodule

`default_nettype wire

//--- sim/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int READ_LATENCY = 2;
  localparam int RANDOM_INSTRS = 200;
  localparam int CYCLES_PER_INSTR = 20;
  localparam int CLK_PERIOD = 100;

  logic clk = 1'b0;
  logic rst_n;
  ram_addr_t ram_raddr;
  logic ram_re;
  data_t ram_rdata;
  ram_addr_t ram_waddr;
  data_t ram_wdata;
  logic ram_we;
  vram_addr_t vram_waddr;
  data_t vram_wdata;
  logic vram_we;

  // RAM model and the copy the reference model walks
  data_t mem [8192];
  data_t ref_mem [8192];
  data_t rd_pipe [$];

  // Expected writes in program order
  bit exp_vram [$];
  addr_t exp_addr [$];
  data_t exp_data [$];

  logic [15:0] lfsr_state;
  addr_t build_pc;
  int instr_count;
  longint watchdog_ns;
  logic watchdog_armed;

  cpu_top #(
    .READ_LATENCY(READ_LATENCY)
  ) u_cpu_top (
    .clk(clk),
    .rst_n(rst_n),
    .ram_raddr(ram_raddr),
    .ram_re(ram_re),
    .ram_rdata(ram_rdata),
    .ram_waddr(ram_waddr),
    .ram_wdata(ram_wdata),
    .ram_we(ram_we),
    .vram_waddr(vram_waddr),
    .vram_wdata(vram_wdata),
    .vram_we(vram_we)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_ram_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%04h, expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_vram_addr(input string name, input vram_addr_t got,
                                 input vram_addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%03h, expected 0x%03h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Class 0 imm load, 1 zp load, 2 abs load, 3 zp store, 4 abs store
  function automatic data_t opcode_for(input logic [2:0] cls, input logic [1:0] sel);
    case ({cls, sel})
      {3'd0, 2'd0}: return OPC_LDA_IMM;
      {3'd0, 2'd1}: return OPC_LDX_IMM;
      {3'd0, 2'd2}: return OPC_LDY_IMM;
      {3'd1, 2'd0}: return OPC_LDA_ZP;
      {3'd1, 2'd1}: return OPC_LDX_ZP;
      {3'd1, 2'd2}: return OPC_LDY_ZP;
      {3'd2, 2'd0}: return OPC_LDA_ABS;
      {3'd2, 2'd1}: return OPC_LDX_ABS;
      {3'd2, 2'd2}: return OPC_LDY_ABS;
      {3'd3, 2'd0}: return OPC_STA_ZP;
      {3'd3, 2'd1}: return OPC_STX_ZP;
      {3'd3, 2'd2}: return OPC_STY_ZP;
      {3'd4, 2'd0}: return OPC_STA_ABS;
      {3'd4, 2'd1}: return OPC_STX_ABS;
      {3'd4, 2'd2}: return OPC_STY_ABS;
      default: return 8'hEA;
    endcase
  endfunction

  task automatic put_byte(input data_t b);
    mem[ram_addr_t'(build_pc)] = b;
    build_pc = build_pc + 16'd1;
  endtask

  task automatic emit_instr(input data_t opc, input int len, input addr_t operand);
    put_byte(opc);
    if (len > 1) begin
      put_byte(operand[7:0]);
    end
    if (len > 2) begin
      put_byte(operand[15:8]);
    end
    instr_count++;
  endtask

  task automatic emit_random_instr();
    logic [2:0] cls;
    logic [1:0] sel;
    addr_t operand;
    cls = 3'(rand_bits(4) / 3);
    sel = 2'(rand_bits(2) % 3);
    case (cls)
      3'd0, 3'd1, 3'd3: operand = rand_bits(8);
      3'd2: operand = 16'h1000 | rand_bits(12);
      3'd4: begin
        if (rand_bits(1) == 16'd1) begin
          operand = VRAM_START + rand_bits(10);
        end else begin
          operand = 16'h1000 | rand_bits(12);
        end
      end
      // Jump to the next instruction
      default: operand = build_pc + 16'd3;
    endcase
    if (cls == 3'd5) begin
      emit_instr(OPC_JMP_ABS, 3, operand);
    end else begin
      emit_instr(opcode_for(cls, sel), (cls == 3'd2 || cls == 3'd4) ? 3 : 2, operand);
    end
  endtask

  task automatic fill_memory();
    for (int a = 0; a < 8192; a++) begin
      mem[ram_addr_t'(a)] = data_t'((a * 7) ^ (a >> 5));
    end
  endtask

  task automatic build_program();
    build_pc = PROGRAM_START;
    // Immediate loads, zero-page stores
    emit_instr(OPC_LDA_IMM, 2, 16'h0011);
    emit_instr(OPC_LDX_IMM, 2, 16'h0022);
    emit_instr(OPC_LDY_IMM, 2, 16'h0033);
    emit_instr(OPC_STA_ZP, 2, 16'h0010);
    emit_instr(OPC_STX_ZP, 2, 16'h0011);
    emit_instr(OPC_STY_ZP, 2, 16'h0012);
    // Loads from preloaded data, then store and load back
    emit_instr(OPC_LDA_ABS, 3, 16'h1234);
    emit_instr(OPC_STA_ZP, 2, 16'h0020);
    emit_instr(OPC_LDX_ZP, 2, 16'h0040);
    emit_instr(OPC_STX_ABS, 3, 16'h1801);
    emit_instr(OPC_LDY_IMM, 2, 16'h00C3);
    emit_instr(OPC_STY_ABS, 3, 16'h1500);
    emit_instr(OPC_LDA_ABS, 3, 16'h1500);
    emit_instr(OPC_STA_ZP, 2, 16'h0021);
    // VRAM edges and the last RAM address below it
    emit_instr(OPC_STA_ABS, 3, VRAM_START);
    emit_instr(OPC_STX_ABS, 3, 16'hE3E7);
    emit_instr(OPC_STY_ABS, 3, 16'hDFFF);
    // Skipped store, then unknown opcodes
    emit_instr(OPC_JMP_ABS, 3, build_pc + 16'd5);
    emit_instr(OPC_STA_ZP, 2, 16'h0030);
    emit_instr(8'hEA, 1, 16'h0000);
    emit_instr(8'h02, 1, 16'h0000);
    emit_instr(8'hFF, 1, 16'h0000);
    emit_instr(OPC_STX_ZP, 2, 16'h0031);
    repeat (RANDOM_INSTRS) begin
      emit_random_instr();
    end
    emit_instr(OPC_JMP_ABS, 3, build_pc);
  endtask

  function automatic void expect_write(input addr_t a, input data_t d);
    if (a >= VRAM_START) begin
      exp_vram.push_back(1'b1);
      exp_addr.push_back(a - VRAM_START);
    end else begin
      exp_vram.push_back(1'b0);
      exp_addr.push_back({3'b000, a[12:0]});
      ref_mem[a[12:0]] = d;
    end
    exp_data.push_back(d);
  endfunction

  // Walks the program and lists every write it should make
  function automatic void run_reference();
    data_t regs [3];
    addr_t pc;
    addr_t target;
    data_t opc;
    data_t lo;
    data_t hi;
    int cls;
    logic [1:0] sel;
    int steps;
    bit done;
    regs = '{default: 8'h00};
    pc = PROGRAM_START;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 100000) begin
      opc = ref_mem[ram_addr_t'(pc)];
      lo = ref_mem[ram_addr_t'(pc + 16'd1)];
      hi = ref_mem[ram_addr_t'(pc + 16'd2)];
      target = {hi, lo};
      cls = -1;
      sel = 2'd0;
      for (int k = 0; k < 5; k++) begin
        for (int r = 0; r < 3; r++) begin
          if (opcode_for(3'(k), 2'(r)) == opc) begin
            cls = k;
            sel = 2'(r);
          end
        end
      end
      if (opc == OPC_JMP_ABS) begin
        // Jump to itself ends the program
        done = (target == pc);
        pc = target;
      end else begin
        case (cls)
          0: regs[sel] = lo;
          1: regs[sel] = ref_mem[ram_addr_t'({8'h00, lo})];
          2: regs[sel] = ref_mem[ram_addr_t'(target)];
          3: expect_write({8'h00, lo}, regs[sel]);
          4: expect_write(target, regs[sel]);
          default: ;
        endcase
        if (cls == 2 || cls == 4) begin
          pc = pc + 16'd3;
        end else if (cls >= 0) begin
          pc = pc + 16'd2;
        end else begin
          pc = pc + 16'd1;
        end
      end
      steps++;
    end
  endfunction

  // RAM read pipeline and write port
  always @(negedge clk) begin
    if (ram_we) begin
      mem[ram_waddr] = ram_wdata;
    end
    rd_pipe.push_back(ram_re ? mem[ram_raddr] : 8'h00);
    ram_rdata = rd_pipe.pop_front();
  end

  always @(negedge clk) begin
    if (rst_n && (ram_we || vram_we)) begin
      if (ram_we && vram_we) begin
        abort_run("RAM and VRAM were written in the same cycle");
      end else if (exp_data.size() == 0) begin
        abort_run("A write happened when no write was expected");
      end else if (ram_we && exp_vram[0]) begin
        abort_run("RAM was written where a VRAM write was expected");
      end else if (vram_we && !exp_vram[0]) begin
        abort_run("VRAM was written where a RAM write was expected");
      end else begin
        if (ram_we) begin
          check_ram_addr("ram_waddr", ram_waddr, ram_addr_t'(exp_addr[0]));
          check_data("ram_wdata", ram_wdata, exp_data[0]);
        end else begin
          check_vram_addr("vram_waddr", vram_waddr, vram_addr_t'(exp_addr[0]));
          check_data("vram_wdata", vram_wdata, exp_data[0]);
        end
        void'(exp_vram.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  initial begin
    wait (watchdog_armed === 1'b1);
    #(watchdog_ns);
    abort_run($sformatf("Timeout after %0d ns, the program did not finish", watchdog_ns));
  end

  initial begin
    rst_n = 1'b0;
    ram_rdata = 8'h00;
    lfsr_state = 16'd44775;
    instr_count = 0;
    watchdog_armed = 1'b0;
    repeat (READ_LATENCY - 1) begin
      rd_pipe.push_back(8'h00);
    end
    fill_memory();
    build_program();
    ref_mem = mem;
    run_reference();
    watchdog_ns = longint'(instr_count) * CYCLES_PER_INSTR * CLK_PERIOD;
    watchdog_armed = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    // First fetch comes from the reset vector
    while (!ram_re) begin
      @(negedge clk);
    end
    check_ram_addr("ram_raddr", ram_raddr, ram_addr_t'(PROGRAM_START));
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    // The final JMP loop must not write
    repeat (10) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/cpu_pkg.sv
verilog/instr_if.sv
verilog/store_if.sv
verilog/fetch_unit.sv
verilog/exec_unit.sv
verilog/store_unit.sv
verilog/cpu_top.sv
sim/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
BUILD_DIR ?= build
ARGS ?=
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' src.f)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when the file list or a source changes
$(SIM_BIN): src.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f src.f --Mdir $(BUILD_DIR) -o V$(TOP)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(ARGS)

clean:
	rm -rf $(BUILD_DIR)
